// ==== Makefile ====
# Verilator build and run for the SoC peripheral testbench

VERILATOR  ?= verilator
TOP        ?= tb_soc_top
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --timescale 1ns/100ps -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/100ps
PASS_TEXT  ?= SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Fails unless the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== compile.f ====
rtl/soc_pkg.sv
rtl/key_if.sv
rtl/ps2_decoder.sv
rtl/key_fifo.sv
rtl/bus_controller.sv
rtl/soc_top.sv
tests/tb_soc_top.sv

// ==== rtl/bus_controller.sv ====
`default_nettype none
`timescale 1ns/100ps

module bus_controller (
    input wire                      CLOCK_50,
    input wire                      KEY0,

    // CPU bus
    input wire soc_pkg::addr_t      bus_address,
    input wire soc_pkg::data_t      bus_write_data,
    input wire                      bus_write_enable,
    input wire                      bus_read_enable,
    output soc_pkg::data_t          bus_read_data,

    // Key FIFO head
    input wire soc_pkg::key_event_t key_head,
    input wire                      key_empty,
    output logic                    key_pop,

    // UART transmit
    output logic [7:0]              uart_data,
    output logic                    uart_write,

    // Interrupts
    output soc_pkg::irq_t           interrupt_vector,
    input wire                      interrupt_ack
);

    localparam int mem_addr_w = $clog2(soc_pkg::mem_words);

    // ROM and RAM share one array, ROM at the bottom
    soc_pkg::mem_word_t    mem [soc_pkg::mem_words];

    logic                  rom_sel;
    logic                  ram_sel;
    logic                  key_sel;
    logic                  art_sel;
    logic [mem_addr_w-1:0] word_index;

    logic                  uart_trigger;
    logic                  uart_trigger_dly;
    logic                  uart_first;

    logic                  empty_dly;
    logic                  irq_set;

    // Address decode
    assign rom_sel = (bus_address >= soc_pkg::rom_base) &&
                     (bus_address <  soc_pkg::rom_base + soc_pkg::rom_size);
    assign ram_sel = (bus_address >= soc_pkg::ram_base) &&
                     (bus_address <  soc_pkg::ram_base + soc_pkg::ram_size);
    assign key_sel = (bus_address == soc_pkg::key_base);
    assign art_sel = (bus_address == soc_pkg::art_base);

    // Byte address to word index
    assign word_index = bus_address[2 +: mem_addr_w];

    // Memory starts out zeroed
    initial begin
        for (int i = 0; i < soc_pkg::mem_words; i++) begin
            mem[i] = '0;
        end
    end

    // Only RAM is writable, ROM writes fall on the floor
    always_ff @(posedge CLOCK_50) begin
        if (bus_write_enable && ram_sel) begin
            mem[word_index] <= bus_write_data[31:0];
        end
    end

    // Key read pops the head in the same cycle it is sampled
    assign key_pop = bus_read_enable && key_sel && !key_empty;

    // Registered read mux, zero whenever read_enable was low
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_data <= '0;
        end else if (bus_read_enable) begin
            if (rom_sel || ram_sel) begin
                bus_read_data <= {32'd0, mem[word_index]};
            end else if (key_sel && !key_empty) begin
                // Bit 8 flags a valid key
                bus_read_data <= {55'd0, 1'b1, key_head.ascii};
            end else begin
                bus_read_data <= '0;
            end
        end else begin
            bus_read_data <= '0;
        end
    end

    // UART strobe on the first cycle of a write burst
    assign uart_trigger = bus_write_enable && art_sel;
    assign uart_first   = uart_trigger && !uart_trigger_dly;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            uart_trigger_dly <= 1'b0;
            uart_write       <= 1'b0;
        end else begin
            uart_trigger_dly <= uart_trigger;
            uart_write       <= uart_first;
        end
    end

    // Byte latched alongside the strobe
    always_ff @(posedge CLOCK_50) begin
        if (uart_first) begin
            uart_data <= bus_write_data[7:0];
        end
    end

    // Interrupt set on FIFO going non-empty
    assign irq_set = !key_empty && empty_dly;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            empty_dly        <= 1'b1;
            interrupt_vector <= '0;
        end else begin
            empty_dly <= key_empty;
            // Ack takes priority over a fresh set
            if (interrupt_ack && (interrupt_vector != '0)) begin
                interrupt_vector <= '0;
            end else if (irq_set) begin
                interrupt_vector <= soc_pkg::irq_keyboard;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/key_fifo.sv ====
`default_nettype none
`timescale 1ns/100ps

module key_fifo #(
    parameter type payload_t  = logic [15:0],
    // Power of two, two or more
    parameter int  fifo_depth = 8
) (
    input wire        CLOCK_50,
    input wire        KEY0,
    key_if.consumer   key,
    output payload_t  head,
    output logic      empty,
    input wire        pop
);

    localparam int ptr_w = $clog2(fifo_depth);

    // Storage
    payload_t         mem [fifo_depth];

    // Pointers wrap naturally at the power-of-two depth
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;

    logic             do_push;
    logic             do_pop;
    payload_t         wr_data;

    // Interface fields packed in payload order, scan above ascii
    assign wr_data = payload_t'({key.scan, key.ascii});

    assign key.full = (count == fifo_depth[ptr_w:0]);
    assign empty    = (count == '0);

    // Full drops the event, empty ignores the pop
    assign do_push = key.valid && !key.full;
    assign do_pop  = pop && !empty;

    // First-word fall-through head
    assign head = mem[rd_ptr];

    always_ff @(posedge CLOCK_50) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/key_if.sv ====
`default_nettype none
`timescale 1ns/100ps

interface key_if;

    // Event payload
    logic [7:0] scan;
    logic [7:0] ascii;

    // One-cycle push strobe from the decoder
    logic       valid;

    // FIFO level, high when no slot is free
    logic       full;

    // Decoder side
    modport producer (
        output valid,
        output scan,
        output ascii,
        input  full
    );

    // FIFO side
    modport consumer (
        input  valid,
        input  scan,
        input  ascii,
        output full
    );

endinterface

`default_nettype wire

// ==== rtl/ps2_decoder.sv ====
`default_nettype none
`timescale 1ns/100ps

module ps2_decoder #(
    parameter int ps2_filter = 4
) (
    input wire       CLOCK_50,
    input wire       KEY0,
    input wire       ps2_clk,
    input wire       ps2_dat,
    key_if.producer  key
);

    // Two-flop synchronizers, idle level is high
    logic [1:0]            clk_sync;
    logic [1:0]            dat_sync;

    // Glitch filter history, at least two samples
    logic [ps2_filter-1:0] clk_hist;
    logic [ps2_filter-1:0] dat_hist;
    logic                  clk_filt;
    logic                  dat_filt;
    logic                  clk_filt_dly;
    logic                  clk_fall;

    // Frame assembly, LSB first: start, 8 data, parity, stop
    logic [10:0]           frame;
    logic [3:0]            bit_count;
    logic                  frame_done;
    logic                  frame_ok;
    logic [7:0]            code;

    // Set by 0xF0, the next code is a release
    logic                  break_armed;

    // Set 2 scan code to lower case ASCII
    function automatic logic [7:0] scan_to_ascii(input logic [7:0] sc);
        case (sc)
            8'h1C: scan_to_ascii = "a";
            8'h32: scan_to_ascii = "b";
            8'h21: scan_to_ascii = "c";
            8'h23: scan_to_ascii = "d";
            8'h24: scan_to_ascii = "e";
            8'h2B: scan_to_ascii = "f";
            8'h34: scan_to_ascii = "g";
            8'h33: scan_to_ascii = "h";
            8'h43: scan_to_ascii = "i";
            8'h3B: scan_to_ascii = "j";
            8'h42: scan_to_ascii = "k";
            8'h4B: scan_to_ascii = "l";
            8'h3A: scan_to_ascii = "m";
            8'h31: scan_to_ascii = "n";
            8'h44: scan_to_ascii = "o";
            8'h4D: scan_to_ascii = "p";
            8'h15: scan_to_ascii = "q";
            8'h2D: scan_to_ascii = "r";
            8'h1B: scan_to_ascii = "s";
            8'h2C: scan_to_ascii = "t";
            8'h3C: scan_to_ascii = "u";
            8'h2A: scan_to_ascii = "v";
            8'h1D: scan_to_ascii = "w";
            8'h22: scan_to_ascii = "x";
            8'h35: scan_to_ascii = "y";
            8'h1A: scan_to_ascii = "z";
            8'h45: scan_to_ascii = "0";
            8'h16: scan_to_ascii = "1";
            8'h1E: scan_to_ascii = "2";
            8'h26: scan_to_ascii = "3";
            8'h25: scan_to_ascii = "4";
            8'h2E: scan_to_ascii = "5";
            8'h36: scan_to_ascii = "6";
            8'h3D: scan_to_ascii = "7";
            8'h3E: scan_to_ascii = "8";
            8'h46: scan_to_ascii = "9";
            8'h29: scan_to_ascii = " ";
            // Enter gives carriage return
            8'h5A: scan_to_ascii = 8'h0D;
            default: scan_to_ascii = 8'h00;
        endcase
    endfunction

    // Synchronize, then filter: output only moves when all samples agree
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync     <= 2'b11;
            dat_sync     <= 2'b11;
            clk_hist     <= '1;
            dat_hist     <= '1;
            clk_filt     <= 1'b1;
            dat_filt     <= 1'b1;
            clk_filt_dly <= 1'b1;
        end else begin
            clk_sync     <= {clk_sync[0], ps2_clk};
            dat_sync     <= {dat_sync[0], ps2_dat};
            clk_hist     <= {clk_hist[ps2_filter-2:0], clk_sync[1]};
            dat_hist     <= {dat_hist[ps2_filter-2:0], dat_sync[1]};
            if (&clk_hist) begin
                clk_filt <= 1'b1;
            end else if (~|clk_hist) begin
                clk_filt <= 1'b0;
            end
            if (&dat_hist) begin
                dat_filt <= 1'b1;
            end else if (~|dat_hist) begin
                dat_filt <= 1'b0;
            end
            clk_filt_dly <= clk_filt;
        end
    end

    // Device changes data on rising edge, we sample on falling
    assign clk_fall = clk_filt_dly & ~clk_filt;

    // Frame bits shift in from the top
    always_ff @(posedge CLOCK_50) begin
        if (clk_fall) begin
            frame <= {dat_filt, frame[10:1]};
        end
    end

    // Bit counter, frame_done pulses the cycle after bit 11
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bit_count  <= 4'd0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (clk_fall) begin
                if (bit_count == 4'd10) begin
                    bit_count  <= 4'd0;
                    frame_done <= 1'b1;
                end else begin
                    bit_count <= bit_count + 4'd1;
                end
            end
        end
    end

    // Start low, stop high, odd parity over data and parity bit
    assign code     = frame[8:1];
    assign frame_ok = !frame[0] && frame[10] && (^frame[9:1]);

    // Break handling and event strobe
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            break_armed <= 1'b0;
            key.valid   <= 1'b0;
        end else begin
            key.valid <= 1'b0;
            if (frame_done && frame_ok) begin
                if (code == 8'hF0) begin
                    break_armed <= 1'b1;
                end else if (break_armed) begin
                    // Release code swallowed
                    break_armed <= 1'b0;
                end else begin
                    key.valid <= 1'b1;
                end
            end
        end
    end

    // Event payload, qualified by valid
    always_ff @(posedge CLOCK_50) begin
        if (frame_done && frame_ok) begin
            key.scan  <= code;
            key.ascii <= scan_to_ascii(code);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

    // Bus types
    typedef logic [63:0] addr_t;
    typedef logic [63:0] data_t;

    // On-chip memory is word organised, 32 bits per word
    typedef logic [31:0] mem_word_t;

    // Address map, byte addresses
    localparam addr_t rom_base = 64'h0000_0000_0000_0000;
    localparam addr_t rom_size = 64'h0000_0000_0000_1000;
    localparam addr_t ram_base = 64'h0000_0000_0000_1000;
    localparam addr_t ram_size = 64'h0000_0000_0000_2000;

    // Peripheral registers
    localparam addr_t key_base = 64'h0000_0000_0000_3000;
    localparam addr_t art_base = 64'h0000_0000_0000_3008;

    // ROM plus RAM in words
    localparam int mem_words = 3072;

    // One key press as stored in the FIFO
    typedef struct packed {
        logic [7:0] scan;
        logic [7:0] ascii;
    } key_event_t;

    // Interrupt vector seen by the CPU
    typedef logic [3:0] irq_t;

    // Keyboard source
    localparam irq_t irq_keyboard = 4'd1;

endpackage

`default_nettype wire

// ==== rtl/soc_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module soc_top #(
    parameter int fifo_depth = 8,
    parameter int ps2_filter = 4
) (
    input wire                  CLOCK_50,
    input wire                  KEY0,
    input wire                  PS2_CLK,
    input wire                  PS2_DAT,

    // CPU bus
    input wire soc_pkg::addr_t  bus_address,
    input wire soc_pkg::data_t  bus_write_data,
    input wire                  bus_write_enable,
    input wire                  bus_read_enable,
    output soc_pkg::data_t      bus_read_data,

    // Interrupts
    output soc_pkg::irq_t       interrupt_vector,
    input wire                  interrupt_ack,

    // UART transmit
    output logic [7:0]          uart_data,
    output logic                uart_write
);

    // Decoder to FIFO
    key_if key_bus ();

    // FIFO to bus controller
    soc_pkg::key_event_t key_head;
    logic                key_empty;
    logic                key_pop;

    ps2_decoder #(
        .ps2_filter (ps2_filter)
    ) u_ps2_decoder (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .ps2_clk  (PS2_CLK),
        .ps2_dat  (PS2_DAT),
        .key      (key_bus.producer)
    );

    key_fifo #(
        .payload_t  (soc_pkg::key_event_t),
        .fifo_depth (fifo_depth)
    ) u_key_fifo (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .key      (key_bus.consumer),
        .head     (key_head),
        .empty    (key_empty),
        .pop      (key_pop)
    );

    bus_controller u_bus_controller (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data),
        .key_head         (key_head),
        .key_empty        (key_empty),
        .key_pop          (key_pop),
        .uart_data        (uart_data),
        .uart_write       (uart_write),
        .interrupt_vector (interrupt_vector),
        .interrupt_ack    (interrupt_ack)
    );

endmodule

`default_nettype wire

// ==== tests/tb_soc_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_soc_top;

    localparam int fifo_depth   = 8;
    localparam int ps2_filter   = 4;
    localparam int half_period  = 50;
    localparam int drive_delay  = 5;
    localparam int reset_cycles = 16;

    // PS/2 half period in system cycles
    localparam int ps2_half = 20;
    // 11 bits of two halves, plus one full idle bit between frames
    localparam int frame_cycles = 24 * ps2_half;
    // Key path 9, overflow depth plus 2, interrupt 1
    localparam int frame_count = 9 + (fifo_depth + 2) + 1;
    localparam int bus_cycles  = 4000;
    localparam longint run_cycles  = reset_cycles + frame_count * frame_cycles + bus_cycles;
    localparam longint watchdog_ns = 2 * run_cycles * 2 * half_period;

    // Reads or cycles spent waiting for a key or an interrupt
    localparam int poll_limit = 100;
    localparam int ram_words  = int'(soc_pkg::ram_size / 4);

    // Set 2 scan codes, a to z then 0 to 9
    localparam logic [7:0] letter_codes [26] = '{
        8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B,
        8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C,
        8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A
    };
    localparam logic [7:0] digit_codes [10] = '{
        8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46
    };

    logic                  CLOCK_50;
    logic                  KEY0;
    logic                  PS2_CLK;
    logic                  PS2_DAT;
    soc_pkg::addr_t        bus_address;
    soc_pkg::data_t        bus_write_data;
    logic                  bus_write_enable;
    logic                  bus_read_enable;
    soc_pkg::data_t        bus_read_data;
    soc_pkg::irq_t         interrupt_vector;
    logic                  interrupt_ack;
    logic [7:0]            uart_data;
    logic                  uart_write;

    // Scoreboard state
    int                    error_count;
    int                    check_count;
    int                    tests_run;
    int                    tests_failed;
    int                    test_error_base;
    string                 test_name;

    // UART monitor
    int                    uart_pulses;
    logic [7:0]            uart_seen;

    // Reference model
    logic [7:0]            expected_keys [$];
    soc_pkg::mem_word_t    mem_model [soc_pkg::mem_words];

    soc_top #(
        .fifo_depth (fifo_depth),
        .ps2_filter (ps2_filter)
    ) UUT (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .PS2_CLK          (PS2_CLK),
        .PS2_DAT          (PS2_DAT),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data),
        .interrupt_vector (interrupt_vector),
        .interrupt_ack    (interrupt_ack),
        .uart_data        (uart_data),
        .uart_write       (uart_write)
    );

    always #(half_period) CLOCK_50 = ~CLOCK_50;

    // Count strobes mid-cycle where the output is settled
    always @(negedge CLOCK_50) begin
        if (KEY0 && uart_write) begin
            uart_pulses = uart_pulses + 1;
            uart_seen   = uart_data;
        end
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout: run did not finish within %0d ns", watchdog_ns);
        $display("SIMULATION FAILED");
        $finish;
    end

    // ROM starts at address zero
    function automatic bit in_memory(input soc_pkg::addr_t addr);
        return (addr < soc_pkg::rom_base + soc_pkg::rom_size) ||
               ((addr >= soc_pkg::ram_base) &&
                (addr < soc_pkg::ram_base + soc_pkg::ram_size));
    endfunction

    function automatic bit in_ram(input soc_pkg::addr_t addr);
        return (addr >= soc_pkg::ram_base) &&
               (addr < soc_pkg::ram_base + soc_pkg::ram_size);
    endfunction

    // Memory words zero-extended, everything else reads zero
    function automatic soc_pkg::data_t expected_read(input soc_pkg::addr_t addr);
        if (in_memory(addr)) begin
            return {32'd0, mem_model[addr[13:2]]};
        end
        return '0;
    endfunction

    // Lower case letters, digits, space and carriage return
    function automatic logic [7:0] expected_ascii(input logic [7:0] code);
        if (code == 8'h29) begin
            return 8'h20;
        end
        if (code == 8'h5A) begin
            return 8'h0D;
        end
        for (int i = 0; i < 26; i++) begin
            if (letter_codes[i] == code) begin
                return 8'h61 + 8'(i);
            end
        end
        for (int i = 0; i < 10; i++) begin
            if (digit_codes[i] == code) begin
                return 8'h30 + 8'(i);
            end
        end
        return 8'h00;
    endfunction

    // Valid flag in bit 8 over the ASCII byte
    function automatic soc_pkg::data_t key_word(input logic [7:0] ascii);
        soc_pkg::data_t word;
        word      = '0;
        word[8]   = 1'b1;
        word[7:0] = ascii;
        return word;
    endfunction

    // Only RAM takes writes
    task automatic model_write(input soc_pkg::addr_t addr, input soc_pkg::data_t data);
        if (in_ram(addr)) begin
            mem_model[addr[13:2]] = data[31:0];
        end
    endtask

    task automatic compare_data(input string what, input soc_pkg::data_t got,
                                input soc_pkg::data_t exp);
        check_count = check_count + 1;
        if (got !== exp) begin
            error_count = error_count + 1;
            $display("[ERROR] %0t ns: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_irq(input string what, input soc_pkg::irq_t got,
                               input soc_pkg::irq_t exp);
        check_count = check_count + 1;
        if (got !== exp) begin
            error_count = error_count + 1;
            $display("[ERROR] %0t ns: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_uart(input string what, input logic [7:0] got,
                                input logic [7:0] exp);
        check_count = check_count + 1;
        if (got !== exp) begin
            error_count = error_count + 1;
            $display("[ERROR] %0t ns: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_flag(input string what, input logic got, input logic exp);
        check_count = check_count + 1;
        if (got !== exp) begin
            error_count = error_count + 1;
            $display("[ERROR] %0t ns: %s got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compare_count(input string what, input int got, input int exp);
        check_count = check_count + 1;
        if (got != exp) begin
            error_count = error_count + 1;
            $display("[ERROR] %0t ns: %s got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        test_error_base = error_count;
    endtask

    task automatic report_test();
        tests_run = tests_run + 1;
        if (error_count != test_error_base) begin
            tests_failed = tests_failed + 1;
            $display("Test %s: %0d errors", test_name, error_count - test_error_base);
        end else begin
            $display("Test %s: ok", test_name);
        end
    endtask

    // Inputs always change just after the edge
    task automatic tick();
        @(posedge CLOCK_50);
        #(drive_delay);
    endtask

    task automatic bus_write(input soc_pkg::addr_t addr, input soc_pkg::data_t data);
        bus_address      = addr;
        bus_write_data   = data;
        bus_write_enable = 1'b1;
        tick();
        bus_write_enable = 1'b0;
    endtask

    // Result holds after the sampling edge
    task automatic bus_read(input soc_pkg::addr_t addr, output soc_pkg::data_t value);
        bus_address     = addr;
        bus_read_enable = 1'b1;
        tick();
        value           = bus_read_data;
        bus_read_enable = 1'b0;
    endtask

    // Start, 8 data LSB first, odd parity, stop
    task automatic send_ps2_byte(input logic [7:0] code, input bit bad_parity);
        logic [10:0] bits;
        bits = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            PS2_DAT = bits[i];
            repeat (ps2_half) tick();
            PS2_CLK = 1'b0;
            repeat (ps2_half) tick();
            PS2_CLK = 1'b1;
        end
        PS2_DAT = 1'b1;
        // Idle gap lets the event land in the FIFO
        repeat (2 * ps2_half) tick();
    endtask

    task automatic send_press(input logic [7:0] code, input bit expect_event);
        send_ps2_byte(code, 1'b0);
        if (expect_event) begin
            expected_keys.push_back(expected_ascii(code));
        end
    endtask

    // Keep reading the key register until a valid entry shows up
    task automatic poll_key(input string what, output soc_pkg::data_t value);
        int tries;
        tries = 0;
        value = '0;
        while (!value[8] && tries < poll_limit) begin
            bus_read(soc_pkg::key_base, value);
            tries = tries + 1;
        end
        if (!value[8]) begin
            error_count = error_count + 1;
            $display("No key event arrived for %s after %0d reads at %0t ns",
                     what, tries, $time);
        end
    endtask

    task automatic drain_expected(input string what);
        soc_pkg::data_t value;
        while (expected_keys.size() > 0) begin
            poll_key(what, value);
            compare_data(what, value, key_word(expected_keys.pop_front()));
        end
    endtask

    task automatic reset_state();
        start_test("reset state");
        compare_data("read data after reset", bus_read_data, '0);
        compare_flag("uart_write after reset", uart_write, 1'b0);
        compare_irq("interrupt vector after reset", interrupt_vector, '0);
        tick();
        compare_data("read data idle", bus_read_data, '0);
        report_test();
    endtask

    task automatic memory_access();
        soc_pkg::addr_t addrs [$];
        soc_pkg::addr_t unmapped [4];
        soc_pkg::addr_t addr;
        soc_pkg::data_t wdata;
        soc_pkg::data_t value;
        int unsigned    word_sel;
        start_test("memory access");
        repeat (16) begin
            word_sel = $urandom % ram_words;
            addr     = soc_pkg::ram_base + soc_pkg::addr_t'(word_sel) * 4;
            wdata    = {$urandom, $urandom};
            bus_write(addr, wdata);
            model_write(addr, wdata);
            addrs.push_back(addr);
        end
        foreach (addrs[i]) begin
            bus_read(addrs[i], value);
            compare_data("RAM readback", value, expected_read(addrs[i]));
        end
        // Output falls back to zero once enable is low
        tick();
        compare_data("read data after enable drop", bus_read_data, '0);
        bus_write(64'h40, 64'hDEAD_BEEF_CAFE_F00D);
        model_write(64'h40, 64'hDEAD_BEEF_CAFE_F00D);
        bus_read(64'h40, value);
        compare_data("ROM word after write", value, expected_read(64'h40));
        // Top ROM word, just below the RAM boundary
        bus_write(64'hFFC, 64'h0000_0000_1234_5678);
        model_write(64'hFFC, 64'h0000_0000_1234_5678);
        bus_read(64'hFFC, value);
        compare_data("last ROM word", value, expected_read(64'hFFC));
        // Known word at the RAM base, where a truncated address would land
        bus_write(soc_pkg::ram_base, 64'h0000_0000_5A5A_A5A5);
        model_write(soc_pkg::ram_base, 64'h0000_0000_5A5A_A5A5);
        unmapped = '{64'h3004, 64'h3010, 64'h9000, 64'h1_0000_1000};
        foreach (unmapped[i]) begin
            bus_read(unmapped[i], value);
            compare_data("unmapped read", value, expected_read(unmapped[i]));
        end
        report_test();
    endtask

    task automatic key_path();
        // Letter, digit, space, enter, and Esc which has no ASCII
        logic [7:0]     presses [5] = '{8'h1C, 8'h2E, 8'h29, 8'h5A, 8'h76};
        soc_pkg::data_t value;
        start_test("key path");
        foreach (presses[i]) begin
            send_press(presses[i], 1'b1);
        end
        drain_expected("key read in order");
        bus_read(soc_pkg::key_base, value);
        compare_data("empty FIFO read", value, '0);
        // Release of a, then a frame with flipped parity
        send_press(8'hF0, 1'b0);
        send_press(8'h1C, 1'b0);
        send_ps2_byte(8'h1C, 1'b1);
        bus_read(soc_pkg::key_base, value);
        compare_data("read after break and bad parity", value, '0);
        send_press(8'h4D, 1'b1);
        drain_expected("key after recovery");
        report_test();
    endtask

    task automatic fifo_overflow();
        soc_pkg::data_t value;
        start_test("FIFO overflow");
        for (int i = 0; i < fifo_depth + 2; i++) begin
            send_press(letter_codes[i], i < fifo_depth);
        end
        drain_expected("overflow key");
        bus_read(soc_pkg::key_base, value);
        compare_data("read after overflow drain", value, '0);
        report_test();
    endtask

    task automatic uart_pulse();
        soc_pkg::data_t burst [3] = '{64'h1122_3344_5566_77A5, 64'h0000_0000_0000_003C,
                                      64'hFFFF_FFFF_FFFF_FFC3};
        start_test("UART pulse");
        uart_pulses      = 0;
        bus_address      = soc_pkg::art_base;
        bus_write_enable = 1'b1;
        foreach (burst[i]) begin
            bus_write_data = burst[i];
            tick();
        end
        bus_write_enable = 1'b0;
        repeat (4) tick();
        // Only the first write of the burst goes out
        compare_count("uart_write pulses", uart_pulses, 1);
        compare_uart("byte at pulse", uart_seen, burst[0][7:0]);
        compare_uart("uart_data after burst", uart_data, burst[0][7:0]);
        compare_flag("uart_write after burst", uart_write, 1'b0);
        report_test();
    endtask

    task automatic keyboard_irq();
        int waited;
        start_test("keyboard interrupt");
        // Clear anything left from the key tests
        interrupt_ack = 1'b1;
        tick();
        interrupt_ack = 1'b0;
        compare_irq("vector before press", interrupt_vector, '0);
        send_press(8'h1D, 1'b1);
        waited = 0;
        while (interrupt_vector == '0 && waited < poll_limit) begin
            tick();
            waited = waited + 1;
        end
        compare_irq("vector after press", interrupt_vector, soc_pkg::irq_keyboard);
        repeat (10) begin
            tick();
            compare_irq("vector held without ack", interrupt_vector, soc_pkg::irq_keyboard);
        end
        interrupt_ack = 1'b1;
        tick();
        compare_irq("vector the cycle after ack", interrupt_vector, '0);
        interrupt_ack = 1'b0;
        drain_expected("key behind interrupt");
        report_test();
    endtask

    initial begin
        CLOCK_50         = 1'b0;
        KEY0             = 1'b0;
        PS2_CLK          = 1'b1;
        PS2_DAT          = 1'b1;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_write_enable = 1'b0;
        bus_read_enable  = 1'b0;
        interrupt_ack    = 1'b0;
        error_count      = 0;
        check_count      = 0;
        tests_run        = 0;
        tests_failed     = 0;
        uart_pulses      = 0;
        uart_seen        = '0;
        void'($urandom(32'h4314));
        for (int i = 0; i < soc_pkg::mem_words; i++) begin
            mem_model[i] = '0;
        end

        repeat (reset_cycles) @(posedge CLOCK_50);
        #(drive_delay);
        KEY0 = 1'b1;

        reset_state();
        memory_access();
        key_path();
        fifo_overflow();
        uart_pulse();
        keyboard_irq();

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
